// ==== hw/lc3Pkg.sv ====
`default_nettype none

package lc3Pkg;

  // One data or address word
  typedef logic [15:0] word_t;

  // Kept opcodes as they sit in IR[15:12]
  typedef enum logic [3:0] {
    OpBr    = 4'b0000,
    OpAdd   = 4'b0001,
    OpAnd   = 4'b0101,
    OpLdr   = 4'b0110,
    OpStr   = 4'b0111,
    OpNot   = 4'b1001,
    OpJmp   = 4'b1100,
    OpPause = 4'b1101
  } opcode_t;

  // Controller states
  typedef enum logic [3:0] {
    Idle, Fetch1, Fetch2, Fetch3, Decode,
    ExecAlu, ExecBr, ExecJmp,
    MemAddr, MemRead1, MemRead2, MemWrite,
    Pause
  } state_t;

  // AluPass forwards the register named by IR[11:9]
  typedef enum logic [1:0] {AluAdd, AluAnd, AluNot, AluPass} aluOp_t;

  // Internal bus sources
  typedef enum logic [1:0] {BusPc, BusAlu, BusMdr, BusMarAdder} busSel_t;

  // PC mux selects
  localparam logic [1:0] PcInc   = 2'd0;
  localparam logic [1:0] PcAdder = 2'd1;
  localparam logic [1:0] PcBase  = 2'd2;

  // On-chip program RAM
  localparam int MemWords    = 256;
  localparam int MemAddrBits = 8;

  // Switches on read, hex display on write
  localparam word_t IoAddr = 16'hFFFF;

endpackage

`default_nettype wire

// ==== hw/lc3Datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3Datapath (
  input  wire                  Clk,
  input  wire                  rst,
  input  wire                  ldMar,
  input  wire                  ldMdr,
  input  wire                  ldIr,
  input  wire                  ldPc,
  input  wire                  ldReg,
  input  wire                  ldCc,
  input  wire                  mdrFromMem,
  input  wire [1:0]            pcSel,
  input  wire lc3Pkg::busSel_t busSel,
  input  wire lc3Pkg::aluOp_t  aluOp,
  input  wire lc3Pkg::word_t   memRData,
  output lc3Pkg::word_t        ir,
  output logic [2:0]           nzp,
  output lc3Pkg::word_t        memAddr,
  output lc3Pkg::word_t        memWData
);

  import lc3Pkg::*;

  // Architectural state
  word_t regFile [8];
  word_t pc;
  word_t mar;
  word_t mdr;

  // Register fields straight from IR
  logic [2:0] dr;
  logic [2:0] sr1;
  logic [2:0] sr2;

  // Read ports
  word_t srA;
  word_t srB;
  word_t srSt;

  // Sign-extended immediates
  word_t imm5Ext;
  word_t off6Ext;
  word_t off9Ext;

  word_t aluB;
  word_t aluOut;
  word_t adderOut;
  word_t mdrD;
  word_t pcD;
  word_t bus;

  assign dr  = ir[11:9];
  assign sr1 = ir[8:6];
  assign sr2 = ir[2:0];

  assign srA  = regFile[sr1];
  assign srB  = regFile[sr2];
  // STR source shares the DR field
  assign srSt = regFile[dr];

  assign imm5Ext = {{11{ir[4]}}, ir[4:0]};
  assign off6Ext = {{10{ir[5]}}, ir[5:0]};
  assign off9Ext = {{7{ir[8]}}, ir[8:0]};

  // Immediate form when IR[5] is set
  assign aluB = ir[5] ? imm5Ext : srB;

  always_comb begin
    case (aluOp)
      AluAdd:  aluOut = srA + aluB;
      AluAnd:  aluOut = srA & aluB;
      AluNot:  aluOut = ~srA;
      AluPass: aluOut = srSt;
    endcase
  end

  // Address adder, PC-relative only while the PC mux picks it (BR)
  assign adderOut = (pcSel == PcAdder) ? (pc + off9Ext) : (srA + off6Ext);

  // MDR input, memory data or the store operand
  assign mdrD = mdrFromMem ? memRData : aluOut;

  // BusMdr carries the MDR input so a read lands in IR or a register
  // in the same cycle the data arrives
  always_comb begin
    case (busSel)
      BusPc:       bus = pc;
      BusAlu:      bus = aluOut;
      BusMdr:      bus = mdrD;
      BusMarAdder: bus = adderOut;
    endcase
  end

  always_comb begin
    case (pcSel)
      PcAdder: pcD = adderOut;
      PcBase:  pcD = srA;
      default: pcD = pc + 16'd1;
    endcase
  end

  always_ff @(posedge Clk) begin
    if (rst) begin
      pc <= '0;
    end else if (ldPc) begin
      pc <= pcD;
    end
  end

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regFile[i] <= '0;
      end
    end else if (ldReg) begin
      regFile[dr] <= bus;
    end
  end

  // Condition codes from whatever the bus carries
  always_ff @(posedge Clk) begin
    if (rst) begin
      nzp <= '0;
    end else if (ldCc) begin
      if (bus[15]) begin
        nzp <= 3'b100;
      end else if (bus == '0) begin
        nzp <= 3'b010;
      end else begin
        nzp <= 3'b001;
      end
    end
  end

  // IR, MAR, MDR
  always_ff @(posedge Clk) begin
    if (ldIr) begin
      ir <= mdrD;
    end
    if (ldMar) begin
      mar <= bus;
    end
    if (ldMdr) begin
      mdr <= mdrD;
    end
  end

  assign memAddr  = mar;
  assign memWData = mdr;

  // Once set, flags stay one-hot for good
  aCcHold: assert property (@(posedge Clk) disable iff (rst)
    (nzp != 3'b000) |=> $onehot(nzp));

endmodule

`default_nettype wire

// ==== hw/lc3Control.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3Control (
  input  wire                   Clk,
  input  wire                   rst,
  input  wire                   run,
  input  wire                   resume,
  input  wire lc3Pkg::word_t    ir,
  input  wire [2:0]             nzp,
  output logic                  ldMar,
  output logic                  ldMdr,
  output logic                  ldIr,
  output logic                  ldPc,
  output logic                  ldReg,
  output logic                  ldCc,
  output logic                  mdrFromMem,
  output logic [1:0]            pcSel,
  output lc3Pkg::busSel_t       busSel,
  output lc3Pkg::aluOp_t        aluOp,
  output logic                  memWe,
  output logic                  memRe,
  output logic                  coreIdle,
  output logic                  paused,
  output logic [11:0]           ledOut
);

  import lc3Pkg::*;

  state_t  state;
  state_t  stateNext;
  opcode_t op;
  logic    brTaken;

  assign op       = opcode_t'(ir[15:12]);
  // Any requested flag that is set
  assign brTaken  = |(ir[11:9] & nzp);
  assign coreIdle = (state == Idle);

  always_ff @(posedge Clk) begin
    if (rst) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      Idle:     if (run) stateNext = Fetch1;
      Fetch1:   stateNext = Fetch2;
      Fetch2:   stateNext = Fetch3;
      Fetch3:   stateNext = Decode;
      Decode: begin
        case (op)
          OpAdd, OpAnd, OpNot: stateNext = ExecAlu;
          OpBr:                stateNext = ExecBr;
          OpJmp:               stateNext = ExecJmp;
          OpLdr, OpStr:        stateNext = MemAddr;
          OpPause:             stateNext = Pause;
          // Unknown opcode, treat as no-op
          default:             stateNext = Fetch1;
        endcase
      end
      MemAddr:  stateNext = (op == OpLdr) ? MemRead1 : MemWrite;
      MemRead1: stateNext = MemRead2;
      Pause:    if (resume) stateNext = Fetch1;
      ExecAlu, ExecBr, ExecJmp, MemRead2, MemWrite: stateNext = Fetch1;
      default:  stateNext = Idle;
    endcase
  end

  // Datapath strobes, one state at a time
  always_comb begin
    ldMar      = 1'b0;
    ldMdr      = 1'b0;
    ldIr       = 1'b0;
    ldPc       = 1'b0;
    ldReg      = 1'b0;
    ldCc       = 1'b0;
    mdrFromMem = 1'b0;
    memWe      = 1'b0;
    memRe      = 1'b0;
    pcSel      = PcInc;
    busSel     = BusPc;
    aluOp      = AluAdd;
    case (state)
      Fetch1: begin
        // MAR <= PC, PC <= PC + 1
        ldMar = 1'b1;
        ldPc  = 1'b1;
      end
      Fetch2: memRe = 1'b1;
      Fetch3: begin
        mdrFromMem = 1'b1;
        ldMdr      = 1'b1;
        ldIr       = 1'b1;
      end
      ExecAlu: begin
        busSel = BusAlu;
        ldReg  = 1'b1;
        ldCc   = 1'b1;
        if (op == OpAnd) begin
          aluOp = AluAnd;
        end else if (op == OpNot) begin
          aluOp = AluNot;
        end
      end
      ExecBr: begin
        pcSel = PcAdder;
        ldPc  = brTaken;
      end
      ExecJmp: begin
        pcSel = PcBase;
        ldPc  = 1'b1;
      end
      MemAddr: begin
        busSel = BusMarAdder;
        ldMar  = 1'b1;
        // STR operand into MDR alongside the address
        if (op == OpStr) begin
          aluOp = AluPass;
          ldMdr = 1'b1;
        end
      end
      MemRead1: memRe = 1'b1;
      MemRead2: begin
        mdrFromMem = 1'b1;
        ldMdr      = 1'b1;
        busSel     = BusMdr;
        ldReg      = 1'b1;
        ldCc       = 1'b1;
      end
      MemWrite: memWe = 1'b1;
      default: ;
    endcase
  end

  // paused trails the state by a cycle, ledOut latched entering Pause
  always_ff @(posedge Clk) begin
    if (rst) begin
      paused <= 1'b0;
      ledOut <= '0;
    end else begin
      paused <= (state == Pause);
      if (state == Decode && stateNext == Pause) begin
        ledOut <= ir[11:0];
      end
    end
  end

  aMemExcl: assert property (@(posedge Clk) disable iff (rst)
    !(memWe && memRe));

  // IR only takes the word requested the cycle before
  aIrLoad: assert property (@(posedge Clk) disable iff (rst)
    ldIr |-> (state == Fetch3) && $past(memRe));

endmodule

`default_nettype wire

// ==== hw/lc3Memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3Memory (
  input  wire                             Clk,
  input  wire                             rst,
  input  wire                             memWe,
  input  wire                             memRe,
  input  wire lc3Pkg::word_t              memAddr,
  input  wire lc3Pkg::word_t              memWData,
  input  wire lc3Pkg::word_t              sw,
  input  wire                             progWe,
  input  wire [lc3Pkg::MemAddrBits-1:0]   progAddr,
  input  wire lc3Pkg::word_t              progData,
  input  wire                             coreIdle,
  output lc3Pkg::word_t                   memRData,
  output lc3Pkg::word_t                   hexOut
);

  import lc3Pkg::*;

  word_t ram [MemWords];

  logic                   isIo;
  logic [MemAddrBits-1:0] ramAddr;
  logic                   progLoad;
  logic                   wrEn;
  logic [MemAddrBits-1:0] wrAddr;
  word_t                  wrData;

  assign isIo    = (memAddr == IoAddr);
  // Upper address bits ignored, so RAM aliases
  assign ramAddr = memAddr[MemAddrBits-1:0];

  // Program loading only while the core sits in Idle
  assign progLoad = progWe && coreIdle;

  // Single write port shared by loader and core
  assign wrEn   = progLoad || (memWe && !isIo);
  assign wrAddr = progLoad ? progAddr : ramAddr;
  assign wrData = progLoad ? progData : memWData;

  always_ff @(posedge Clk) begin
    if (wrEn) begin
      ram[wrAddr] <= wrData;
    end
  end

  // Synchronous read, valid the cycle after memRe
  always_ff @(posedge Clk) begin
    if (memRe) begin
      memRData <= isIo ? sw : ram[ramAddr];
    end
  end

  // Hex display register
  always_ff @(posedge Clk) begin
    if (rst) begin
      hexOut <= '0;
    end else if (memWe && isIo) begin
      hexOut <= memWData;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lc3Top.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3Top (
  input  wire                           Clk,
  input  wire                           rst,
  input  wire                           run,
  input  wire                           resume,
  input  wire lc3Pkg::word_t            sw,
  input  wire                           progWe,
  input  wire [lc3Pkg::MemAddrBits-1:0] progAddr,
  input  wire lc3Pkg::word_t            progData,
  output lc3Pkg::word_t                 hexOut,
  output logic [11:0]                   ledOut,
  output logic                          paused
);

  import lc3Pkg::*;

  // Control to datapath strobes
  logic       ldMar;
  logic       ldMdr;
  logic       ldIr;
  logic       ldPc;
  logic       ldReg;
  logic       ldCc;
  logic       mdrFromMem;
  logic [1:0] pcSel;
  busSel_t    busSel;
  aluOp_t     aluOp;

  // Datapath back to control
  word_t      ir;
  logic [2:0] nzp;

  // Memory bus
  logic       memWe;
  logic       memRe;
  logic       coreIdle;
  word_t      memAddr;
  word_t      memWData;
  word_t      memRData;

  lc3Control  control0 (.*);
  lc3Datapath datapath0 (.*);
  lc3Memory   memory0 (.*);

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen (
  output logic Clk
);

  // 4 ns period
  initial begin
    Clk = 1'b0;
  end

  always #2 Clk = ~Clk;

endmodule

`default_nettype wire

// ==== verification/lc3Testbench.sv ====
`timescale 1ns/1ns
`default_nettype none

module lc3Testbench;

  import lc3Pkg::*;

  localparam int ResetCycles = 5;
  localparam int NumProgs    = 6;
  // Executed instructions per program, generous upper bound
  localparam int MaxInstr    = 120;
  localparam int Budget      = NumProgs * (ResetCycles + MemWords + 20 + 40 * MaxInstr);

  logic                   Clk;
  logic                   rst;
  logic                   run;
  logic                   resume;
  word_t                  sw;
  logic                   progWe;
  logic [MemAddrBits-1:0] progAddr;
  word_t                  progData;
  word_t                  hexOut;
  logic [11:0]            ledOut;
  logic                   paused;

  // Reference machine state
  word_t       refMem [MemWords];
  word_t       refReg [8];
  word_t       refPc;
  logic [2:0]  refNzp;
  word_t       refHex;
  logic [11:0] refLed;

  word_t       prog [$];
  int          pauseCount;
  int          checksDone;
  logic        pausedPrev;

  clockGen clk0 (.Clk(Clk));

  lc3Top dut0 (.*);

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic checkLed(input string name, input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [2:0] ccOf(input word_t v);
    if (v[15]) return 3'b100;
    if (v == '0) return 3'b010;
    return 3'b001;
  endfunction

  // One instruction of the ISA subset, returns 1 on PAUSE
  function automatic bit lc3Step();
    word_t   i;
    word_t   a;
    word_t   v;
    word_t   opB;
    opcode_t op;
    i = refMem[refPc[MemAddrBits-1:0]];
    refPc = refPc + 16'd1;
    op = opcode_t'(i[15:12]);
    opB = i[5] ? {{11{i[4]}}, i[4:0]} : refReg[i[2:0]];
    a = refReg[i[8:6]] + {{10{i[5]}}, i[5:0]};
    case (op)
      OpAdd, OpAnd, OpNot: begin
        if (op == OpAdd) v = refReg[i[8:6]] + opB;
        else if (op == OpAnd) v = refReg[i[8:6]] & opB;
        else v = ~refReg[i[8:6]];
        refReg[i[11:9]] = v;
        refNzp = ccOf(v);
      end
      OpBr: if (|(i[11:9] & refNzp)) refPc = refPc + {{7{i[8]}}, i[8:0]};
      OpJmp: refPc = refReg[i[8:6]];
      OpLdr: begin
        v = (a == IoAddr) ? sw : refMem[a[MemAddrBits-1:0]];
        refReg[i[11:9]] = v;
        refNzp = ccOf(v);
      end
      OpStr: begin
        if (a == IoAddr) refHex = refReg[i[11:9]];
        else refMem[a[MemAddrBits-1:0]] = refReg[i[11:9]];
      end
      OpPause: begin
        refLed = i[11:0];
        return 1'b1;
      end
      default: ;
    endcase
    return 1'b0;
  endfunction

  // Instruction encoders
  function automatic word_t encRR(opcode_t op, logic [2:0] dr, logic [2:0] s1, logic [2:0] s2);
    return {op, dr, s1, 3'b000, s2};
  endfunction

  function automatic word_t encRI(opcode_t op, logic [2:0] dr, logic [2:0] s1, logic [4:0] imm);
    return {op, dr, s1, 1'b1, imm};
  endfunction

  function automatic word_t encMem(opcode_t op, logic [2:0] r, logic [2:0] b, logic [5:0] off);
    return {op, r, b, off};
  endfunction

  task automatic emitPause(input logic [11:0] code);
    prog.push_back({OpPause, code});
    pauseCount++;
  endtask

  // Always 15 words, value up to 210
  task automatic setReg(input logic [2:0] r, input int val);
    int rem;
    int step;
    rem = val;
    prog.push_back(encRI(OpAnd, r, r, 5'd0));
    repeat (14) begin
      step = (rem > 15) ? 15 : rem;
      prog.push_back(encRI(OpAdd, r, r, step[4:0]));
      rem -= step;
    end
  endtask

  task automatic randomAlu(output logic [2:0] dr);
    logic [2:0] s1;
    logic [2:0] s2;
    logic [4:0] imm;
    dr  = $urandom_range(5, 0);
    s1  = $urandom_range(5, 0);
    s2  = $urandom_range(5, 0);
    imm = $urandom;
    case ($urandom_range(4, 0))
      0: prog.push_back(encRR(OpAdd, dr, s1, s2));
      1: prog.push_back(encRI(OpAdd, dr, s1, imm));
      2: prog.push_back(encRR(OpAnd, dr, s1, s2));
      3: prog.push_back(encRI(OpAnd, dr, s1, imm));
      default: prog.push_back({OpNot, dr, s1, 6'h3F});
    endcase
  endtask

  // R7 <= IoAddr
  task automatic ioBase();
    prog.push_back(encRI(OpAnd, 3'd7, 3'd7, 5'd0));
    prog.push_back({OpNot, 3'd7, 3'd7, 6'h3F});
  endtask

  // Reset, load the whole RAM, start the core and service each PAUSE
  task automatic runProgram(input bit scribble);
    word_t                  w;
    int                     target;
    logic [MemAddrBits-1:0] nextAddr;
    rst <= 1'b1;
    repeat (ResetCycles) @(posedge Clk);
    rst <= 1'b0;
    for (int a = 0; a < MemWords; a++) begin
      // Unused words hold a PAUSE tagged with their address
      w = (a < prog.size()) ? prog[a] : {OpPause, 4'hF, a[7:0]};
      refMem[a] = w;
      @(posedge Clk);
      progWe   <= 1'b1;
      progAddr <= a[MemAddrBits-1:0];
      progData <= w;
    end
    @(posedge Clk);
    progWe <= 1'b0;
    @(posedge Clk);
    if (paused !== 1'b0) begin
      $display("[FAIL] paused got %h expected %h", paused, 1'b0);
      $display("*** FAILED ***");
      $fatal(1, "paused after reset");
    end
    checkWord("hexOut", hexOut, 16'h0000);
    checkLed("ledOut", ledOut, 12'h000);
    for (int r = 0; r < 8; r++) refReg[r] = '0;
    refPc  = '0;
    refNzp = '0;
    refHex = '0;
    refLed = '0;
    target = checksDone + pauseCount;
    sw  <= $urandom;
    run <= 1'b1;
    @(posedge Clk);
    run <= 1'b0;
    for (int k = 1; k <= pauseCount; k++) begin
      while (checksDone < target - pauseCount + k) @(posedge Clk);
      if (k < pauseCount) begin
        sw     <= $urandom;
        resume <= 1'b1;
        @(posedge Clk);
        resume <= 1'b0;
        // Loader writes while running must be ignored
        if (scribble) begin
          // Aim at the words the core is about to fetch
          nextAddr = refPc[MemAddrBits-1:0];
          repeat (3) begin
            @(posedge Clk);
            progWe   <= 1'b1;
            progAddr <= nextAddr;
            progData <= $urandom;
            nextAddr = nextAddr + 1'b1;
          end
          @(posedge Clk);
          progWe <= 1'b0;
        end
      end
    end
    prog.delete();
    pauseCount = 0;
  endtask

  // Compare at each rising edge of paused
  always @(posedge Clk) begin
    int steps;
    pausedPrev <= paused;
    if (paused && !pausedPrev && !rst) begin
      steps = 0;
      while (!lc3Step()) begin
        steps++;
        if (steps > 1000) begin
          $display("Reference model never reached a PAUSE");
          $display("*** FAILED ***");
          $fatal(1, "reference runaway");
        end
      end
      checkWord("hexOut", hexOut, refHex);
      checkLed("ledOut", ledOut, refLed);
      checksDone <= checksDone + 1;
    end
  end

  initial begin
    repeat (Budget) @(posedge Clk);
    $display("Watchdog expired, the core never paused within the cycle budget");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    logic [2:0] dr;
    int         start;
    int         off;
    void'($urandom(32'h74744448));
    rst        = 1'b1;
    run        = 1'b0;
    resume     = 1'b0;
    sw         = '0;
    progWe     = 1'b0;
    progAddr   = '0;
    progData   = '0;
    pausedPrev = 1'b0;
    checksDone = 0;
    pauseCount = 0;

    // Single PAUSE
    emitPause(12'h123);
    runProgram(1'b0);

    // Random ALU blocks shown through the display
    ioBase();
    repeat (6) begin
      repeat (5) randomAlu(dr);
      prog.push_back(encMem(OpStr, dr, 3'd7, 6'd0));
      emitPause($urandom);
    end
    runProgram(1'b1);

    // Switch echo
    ioBase();
    repeat (4) begin
      prog.push_back(encMem(OpLdr, 3'd1, 3'd7, 6'd0));
      prog.push_back(encMem(OpStr, 3'd1, 3'd7, 6'd0));
      emitPause($urandom);
    end
    runProgram(1'b1);

    // Conditional branch over a store, then JMP over a dead PAUSE
    ioBase();
    repeat (5) begin
      prog.push_back(encRI(OpAdd, 3'd1, 3'd1, 5'($urandom)));
      prog.push_back({OpBr, 3'($urandom), 9'd1});
      prog.push_back(encMem(OpStr, 3'd1, 3'd7, 6'd0));
      emitPause($urandom);
    end
    start = prog.size();
    setReg(3'd3, start + 18);
    prog.push_back({OpJmp, 3'd0, 3'd3, 6'd0});
    prog.push_back(encMem(OpStr, 3'd3, 3'd7, 6'd0));
    prog.push_back({OpPause, 12'hBAD});
    emitPause(12'h5A5);
    runProgram(1'b1);

    // RAM round trip, stores through an aliased base above 255
    ioBase();
    setReg(3'd4, 200);
    setReg(3'd5, 55);
    prog.push_back({OpNot, 3'd5, 3'd5, 6'h3F});
    repeat (3) begin
      off = $urandom_range(7, 0);
      setReg(3'd1, $urandom_range(210, 0));
      if ($urandom_range(1, 0)) prog.push_back({OpNot, 3'd1, 3'd1, 6'h3F});
      prog.push_back(encMem(OpStr, 3'd1, 3'd5, 6'(off)));
      prog.push_back(encMem(OpLdr, 3'd2, 3'd4, 6'(off)));
      prog.push_back(encMem(OpStr, 3'd2, 3'd7, 6'd0));
      emitPause($urandom);
      prog.push_back(encMem(OpStr, 3'd1, 3'd4, 6'(off + 8)));
      prog.push_back(encMem(OpLdr, 3'd6, 3'd4, 6'(off + 8)));
      prog.push_back(encMem(OpStr, 3'd6, 3'd7, 6'd0));
      emitPause($urandom);
    end
    runProgram(1'b1);

    // Mixed ALU program with loader noise after every resume
    ioBase();
    repeat (4) begin
      repeat (3) randomAlu(dr);
      prog.push_back(encMem(OpStr, dr, 3'd7, 6'd0));
      emitPause($urandom);
    end
    runProgram(1'b1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/lc3Pkg.sv
hw/lc3Datapath.sv
hw/lc3Control.sv
hw/lc3Memory.sv
hw/lc3Top.sv
verification/clockGen.sv
verification/lc3Testbench.sv

// ==== Bender.yml ====
package:
  name: lc3

sources:
  - files:
      - hw/lc3Pkg.sv
      - hw/lc3Datapath.sv
      - hw/lc3Control.sv
      - hw/lc3Memory.sv
      - hw/lc3Top.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/lc3Testbench.sv
